//--- project.f
src/dnc_pkg.sv
src/dnc_scalar_adder.sv
src/dnc_scalar_multiplier.sv
src/dnc_link_memory.sv
src/dnc_temporal_link_matrix.sv
src/dnc_link_top.sv
testbench/dnc_link_clock.sv
testbench/dnc_link_assertions.sv
testbench/dnc_link_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module dnc_link_tb -f project.f

# A failing assertion stops the simulator, the search below still decides
sim_out=$(./obj_dir/Vdnc_link_tb) || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "No errors"; then
  exit 0
fi
exit 1

//--- testbench/dnc_link_cases.txt
// Per case one line with size N, N write weights w and N precedence weights p
// then N lines of expected L rows, all Q8.8 hex, size 0000 ends the list
// First update from the all-zero matrix gives w[g]*p[j]
0003 0040 0080 0020 0100 0040 00c0
0000 0010 0030
0080 0000 0060
0020 0008 0000
// Chained on the previous matrix with truncated products
0003 0080 0040 0003 0100 0080 0040
0000 0044 0037
0060 0000 0056
0012 0006 0000
// Large weights drive 1-w-w negative and saturate
0004 7f00 7f00 0100 ff81 0100 8000 0080 ff00
0000 8000 2437 8100
4f00 0000 14d6 8100
f812 8000 0000 ff00
ff81 3f80 ffc0 0000
// Single diagonal element
0001 1234 5678
0000
// Positive product saturation on the old corner values
0002 0100 0200 0300 0080
0000 7fff
8600 0000
0000

//--- testbench/dnc_link_tb.sv
`default_nettype none

module dnc_link_tb
  import dnc_pkg::*;
();

  //////////////////////////////////////////////////////////////////////
  // Signals and DUT
  //////////////////////////////////////////////////////////////////////

  localparam int RESET_CYCLES    = 16;
  localparam int CYCLES_PER_CASE = 200;
  localparam int MEM_WORDS       = 256;

  logic                 CLK;
  logic                 RST;
  logic                 start;
  logic [INDEX_SIZE:0]  size_n;
  logic                 w_en;
  logic [DATA_SIZE-1:0] w_val;
  logic                 p_en;
  logic [DATA_SIZE-1:0] p_val;
  logic                 ready;
  logic                 l_g_en;
  logic                 l_j_en;
  logic [DATA_SIZE-1:0] l_out;

  // Word stream of the cases file
  logic [DATA_SIZE-1:0] case_mem [MEM_WORDS];

  // Captured output stream
  logic [DATA_SIZE-1:0] out_vals [$];
  logic                 out_rows [$];
  int                   ready_count = 0;
  int                   error_count = 0;
  int                   check_count = 0;
  int                   case_count  = 0;

  dnc_link_clock clock_gen (.CLK(CLK));

  dnc_link_top dut_i (
    .CLK            (CLK),
    .RST            (RST),
    .START          (start),
    .SIZE_N_IN      (size_n),
    .READY          (ready),
    .W_IN_ENABLE    (w_en),
    .W_IN           (w_val),
    .P_IN_ENABLE    (p_en),
    .P_IN           (p_val),
    .L_OUT_G_ENABLE (l_g_en),
    .L_OUT_J_ENABLE (l_j_en),
    .L_OUT          (l_out)
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("MISMATCH at %0t: %s is 0x%0h, expected 0x%0h",
               $time, name, actual, expected);
    end
  endtask

  // Header, w, p and the N*N expected words
  function automatic int case_words(input int n);
    return 1 + 2 * n + n * n;
  endfunction

  // One w or p strobe after a gap of 0 to 3 cycles
  task automatic send_weight(input bit to_p, input logic [DATA_SIZE-1:0] value);
    int gap;
    gap = $urandom % 4;
    repeat (gap) @(negedge CLK);
    if (to_p) begin
      p_en  = 1'b1;
      p_val = value;
    end else begin
      w_en  = 1'b1;
      w_val = value;
    end
    @(negedge CLK);
    w_en = 1'b0;
    p_en = 1'b0;
  endtask

  // Drive one update and check its stream against the file
  task automatic run_case(input int base);
    int n;
    int seen;
    int exp_idx;
    n    = int'(case_mem[base]);
    seen = ready_count;
    @(negedge CLK);
    size_n = (INDEX_SIZE + 1)'(n);
    start  = 1'b1;
    @(negedge CLK);
    start = 1'b0;
    for (int k = 0; k < n; k++) begin
      send_weight(1'b0, case_mem[base + 1 + k]);
    end
    for (int k = 0; k < n; k++) begin
      send_weight(1'b1, case_mem[base + 1 + n + k]);
    end
    // Until the update signals READY
    while (ready_count == seen) begin
      @(negedge CLK);
    end
    check_value("column strobe count", out_vals.size(), n * n);
    for (int k = 0; k < n * n && k < out_vals.size(); k++) begin
      exp_idx = base + 1 + 2 * n + k;
      check_value($sformatf("L_OUT[%0d][%0d]", k / n, k % n),
                  32'(out_vals[k]), 32'(case_mem[exp_idx]));
      // Row strobe only on the last column
      check_value($sformatf("L_OUT_G_ENABLE[%0d][%0d]", k / n, k % n),
                  32'(out_rows[k]), 32'((k % n) == n - 1));
    end
    out_vals.delete();
    out_rows.delete();
  endtask

  task automatic watchdog(input int cases);
    repeat (RESET_CYCLES + CYCLES_PER_CASE * cases) @(posedge CLK);
    $display("Timeout: the updates did not finish in %0d cycles",
             RESET_CYCLES + CYCLES_PER_CASE * cases);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    $display("Errors found");
    $finish;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Monitor, sampled on the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge CLK) begin
    if (!RST) begin
      if (l_j_en) begin
        out_vals.push_back(l_out);
        out_rows.push_back(l_g_en);
      end
      if (ready) begin
        ready_count++;
        // READY comes a cycle after the last element
        check_value("L_OUT_J_ENABLE at READY", 32'(l_j_en), 32'(0));
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int base;
    int n;
    void'($urandom(63));
    RST    = 1'b1;
    start  = 1'b0;
    size_n = '0;
    w_en   = 1'b0;
    w_val  = '0;
    p_en   = 1'b0;
    p_val  = '0;
    $readmemh("testbench/dnc_link_cases.txt", case_mem);

    // Count cases for the watchdog budget
    base = 0;
    while (base < MEM_WORDS && case_mem[base] != '0) begin
      n = int'(case_mem[base]);
      if (n > MAX_N) begin
        error_count++;
        $display("Cases file holds a size of %0d, larger than %0d", n, MAX_N);
        break;
      end
      case_count++;
      base += case_words(n);
    end
    if (case_count == 0) begin
      error_count++;
      $display("No update cases were read from the cases file");
    end

    fork
      watchdog(case_count);
    join_none

    repeat (RESET_CYCLES) @(negedge CLK);
    RST = 1'b0;
    // Quiet outputs out of reset
    check_value("READY", 32'(ready), 32'(0));
    check_value("L_OUT_J_ENABLE", 32'(l_j_en), 32'(0));
    check_value("L_OUT_G_ENABLE", 32'(l_g_en), 32'(0));
    check_value("L_OUT", 32'(l_out), 32'(0));

    // Cases chain through the stored matrix
    base = 0;
    repeat (case_count) begin
      run_case(base);
      base += case_words(int'(case_mem[base]));
    end

    // One READY per update
    check_value("READY pulse count", ready_count, case_count);

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/dnc_link_assertions.sv
`default_nettype none

module dnc_link_assertions
  import dnc_pkg::*;
(
  input wire logic        CLK,
  input wire logic        RST,
  input wire logic        READY,
  input wire logic        L_OUT_G_ENABLE,
  input wire logic        L_OUT_J_ENABLE,
  input wire link_write_t wr
);

  //////////////////////////////////////////////////////////////////////
  // Control outputs
  //////////////////////////////////////////////////////////////////////

  // Single cycle pulses
  ready_pulse: assert property (@(posedge CLK) disable iff (RST) READY |=> !READY)
    else $error("READY stayed high for more than one cycle");
  col_pulse: assert property (@(posedge CLK) disable iff (RST)
    L_OUT_J_ENABLE |=> !L_OUT_J_ENABLE)
    else $error("L_OUT_J_ENABLE stayed high for more than one cycle");
  row_pulse: assert property (@(posedge CLK) disable iff (RST)
    L_OUT_G_ENABLE |=> !L_OUT_G_ENABLE)
    else $error("L_OUT_G_ENABLE stayed high for more than one cycle");

  // Row strobe rides on a column strobe
  row_with_col: assert property (@(posedge CLK) disable iff (RST)
    L_OUT_G_ENABLE |-> L_OUT_J_ENABLE)
    else $error("L_OUT_G_ENABLE without L_OUT_J_ENABLE");

  // Diagonal of L is always zero
  diag_zero: assert property (@(posedge CLK) disable iff (RST)
    (wr.en && wr.addr.g == wr.addr.j) |-> wr.value == '0)
    else $error("Nonzero value written to the diagonal");

endmodule

bind dnc_temporal_link_matrix dnc_link_assertions link_assertions_i (
  .CLK            (CLK),
  .RST            (RST),
  .READY          (READY),
  .L_OUT_G_ENABLE (L_OUT_G_ENABLE),
  .L_OUT_J_ENABLE (L_OUT_J_ENABLE),
  .wr             (wr)
);

`default_nettype wire

//--- testbench/dnc_link_clock.sv
`default_nettype none

module dnc_link_clock (
  output logic CLK
);

  // Period 100, low for the first half
  initial begin
    CLK = 1'b0;
  end

  always #50 CLK = ~CLK;

endmodule

`default_nettype wire

//--- src/dnc_link_top.sv
`default_nettype none

module dnc_link_top
  import dnc_pkg::*;
(
  input  wire logic                 CLK,
  input  wire logic                 RST,
  // Control
  input  wire logic                 START,
  input  wire logic [INDEX_SIZE:0]  SIZE_N_IN,
  output logic                      READY,
  // Weightings in
  input  wire logic                 W_IN_ENABLE,
  input  wire logic [DATA_SIZE-1:0] W_IN,
  input  wire logic                 P_IN_ENABLE,
  input  wire logic [DATA_SIZE-1:0] P_IN,
  // Link matrix out, row by row
  output logic                      L_OUT_G_ENABLE,
  output logic                      L_OUT_J_ENABLE,
  output logic [DATA_SIZE-1:0]      L_OUT
);

  //////////////////////////////////////////////////////////////////////
  // Update unit to link memory
  //////////////////////////////////////////////////////////////////////

  link_addr_t           rd_addr;
  logic [DATA_SIZE-1:0] rd_data;
  link_write_t          wr;

  dnc_temporal_link_matrix link_matrix (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .READY          (READY),
    .SIZE_N_IN      (SIZE_N_IN),
    .W_IN_ENABLE    (W_IN_ENABLE),
    .W_IN           (W_IN),
    .P_IN_ENABLE    (P_IN_ENABLE),
    .P_IN           (P_IN),
    .L_OUT_G_ENABLE (L_OUT_G_ENABLE),
    .L_OUT_J_ENABLE (L_OUT_J_ENABLE),
    .L_OUT          (L_OUT),
    .rd_addr        (rd_addr),
    .rd_data        (rd_data),
    .wr             (wr)
  );

  // Holds L between updates
  dnc_link_memory link_memory (
    .CLK     (CLK),
    .RST     (RST),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .wr      (wr)
  );

endmodule

`default_nettype wire

//--- src/dnc_temporal_link_matrix.sv
`default_nettype none

module dnc_temporal_link_matrix
  import dnc_pkg::*;
(
  input  wire logic                 CLK,
  input  wire logic                 RST,
  // Control
  input  wire logic                 START,
  output logic                      READY,
  input  wire logic [INDEX_SIZE:0]  SIZE_N_IN,
  // Write and precedence weightings
  input  wire logic                 W_IN_ENABLE,
  input  wire logic [DATA_SIZE-1:0] W_IN,
  input  wire logic                 P_IN_ENABLE,
  input  wire logic [DATA_SIZE-1:0] P_IN,
  // Updated link matrix stream
  output logic                      L_OUT_G_ENABLE,
  output logic                      L_OUT_J_ENABLE,
  output logic [DATA_SIZE-1:0]      L_OUT,
  // Link memory
  output link_addr_t                rd_addr,
  input  wire logic [DATA_SIZE-1:0] rd_data,
  output link_write_t               wr
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    ST_IDLE, ST_LOAD_W, ST_LOAD_P, ST_READ, ST_SUB_G, ST_SUB_J,
    ST_MUL_L, ST_MUL_WP, ST_ADD, ST_WRITE, ST_DONE
  } state_t;

  state_t state;

  // N-1 and the walking indices
  logic [INDEX_SIZE-1:0] last_idx;
  logic [INDEX_SIZE-1:0] cnt;
  logic [INDEX_SIZE-1:0] g_idx;
  logic [INDEX_SIZE-1:0] j_idx;

  // Captured weightings
  logic [DATA_SIZE-1:0] w_vec [MAX_N];
  logic [DATA_SIZE-1:0] p_vec [MAX_N];
  // (1 - w[g] - w[j]) * L, kept while w[g] * p[j] runs
  logic [DATA_SIZE-1:0] prod_keep;

  // Scalar units
  logic                 add_start;
  logic                 add_ready;
  logic                 add_op;
  logic [DATA_SIZE-1:0] add_a;
  logic [DATA_SIZE-1:0] add_b;
  logic [DATA_SIZE-1:0] add_out;
  logic                 mul_start;
  logic                 mul_ready;
  logic [DATA_SIZE-1:0] mul_a;
  logic [DATA_SIZE-1:0] mul_b;
  logic [DATA_SIZE-1:0] mul_out;

  // Element finished this cycle
  logic                 diag;
  logic                 emit;
  logic [DATA_SIZE-1:0] elem_val;

  //////////////////////////////////////////////////////////////////////
  // Body
  //////////////////////////////////////////////////////////////////////

  // L(t)[g;j] = (1 - w[g] - w[j]) * L(t-1)[g;j] + w[g] * p[j]
  assign rd_addr  = '{g: g_idx, j: j_idx};
  assign diag     = (g_idx == j_idx);
  assign emit     = (state == ST_READ && diag) || (state == ST_ADD && add_ready);
  // Diagonal pinned to zero
  assign elem_val = diag ? '0 : add_out;
  // Subtract everywhere but the final sum
  assign add_op   = (state != ST_ADD);

  // Operand select, sampled by the units in their START cycle
  always_comb begin
    add_a = ONE_DATA;
    add_b = w_vec[g_idx];
    mul_a = add_out;
    mul_b = rd_data;
    case (state)
      ST_SUB_J: begin
        add_a = add_out;
        add_b = w_vec[j_idx];
      end
      ST_MUL_WP: begin
        mul_a = w_vec[g_idx];
        mul_b = p_vec[j_idx];
      end
      ST_ADD: begin
        add_a = prod_keep;
        add_b = mul_out;
      end
      default: ;
    endcase
  end

  // Control FSM
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state          <= ST_IDLE;
      last_idx       <= '0;
      cnt            <= '0;
      g_idx          <= '0;
      j_idx          <= '0;
      add_start      <= 1'b0;
      mul_start      <= 1'b0;
      READY          <= 1'b0;
      L_OUT_G_ENABLE <= 1'b0;
      L_OUT_J_ENABLE <= 1'b0;
      L_OUT          <= '0;
      wr             <= '0;
    end else begin
      add_start <= 1'b0;
      mul_start <= 1'b0;
      case (state)
        ST_IDLE: if (START) begin
          last_idx <= INDEX_SIZE'(SIZE_N_IN - 1'b1);
          cnt      <= '0;
          state    <= ST_LOAD_W;
        end
        ST_LOAD_W: if (W_IN_ENABLE) begin
          cnt <= (cnt == last_idx) ? '0 : cnt + 1'b1;
          if (cnt == last_idx) state <= ST_LOAD_P;
        end
        ST_LOAD_P: if (P_IN_ENABLE) begin
          cnt <= cnt + 1'b1;
          if (cnt == last_idx) begin
            g_idx <= '0;
            j_idx <= '0;
            state <= ST_READ;
          end
        end
        // Off diagonal, 1 - w[g] first
        ST_READ: if (!diag) begin
          add_start <= 1'b1;
          state     <= ST_SUB_G;
        end
        ST_SUB_G: if (add_ready) begin
          add_start <= 1'b1;
          state     <= ST_SUB_J;
        end
        ST_SUB_J: if (add_ready) begin
          mul_start <= 1'b1;
          state     <= ST_MUL_L;
        end
        ST_MUL_L: if (mul_ready) begin
          mul_start <= 1'b1;
          state     <= ST_MUL_WP;
        end
        ST_MUL_WP: if (mul_ready) begin
          add_start <= 1'b1;
          state     <= ST_ADD;
        end
        // Strobes drop, move to next element or finish
        ST_WRITE: begin
          L_OUT_G_ENABLE <= 1'b0;
          L_OUT_J_ENABLE <= 1'b0;
          wr.en          <= 1'b0;
          state          <= ST_READ;
          if (j_idx == last_idx) begin
            j_idx <= '0;
            g_idx <= g_idx + 1'b1;
            if (g_idx == last_idx) begin
              READY <= 1'b1;
              state <= ST_DONE;
            end
          end else begin
            j_idx <= j_idx + 1'b1;
          end
        end
        ST_DONE: begin
          READY <= 1'b0;
          state <= ST_IDLE;
        end
        default: ;
      endcase
      // Output strobe and memory write share one cycle
      if (emit) begin
        L_OUT          <= elem_val;
        L_OUT_J_ENABLE <= 1'b1;
        L_OUT_G_ENABLE <= (j_idx == last_idx);
        wr             <= '{en: 1'b1, addr: rd_addr, value: elem_val};
        state          <= ST_WRITE;
      end
    end
  end

  // Weighting capture and product hold
  always_ff @(posedge CLK) begin
    if (state == ST_LOAD_W && W_IN_ENABLE) w_vec[cnt] <= W_IN;
    if (state == ST_LOAD_P && P_IN_ENABLE) p_vec[cnt] <= P_IN;
    if (state == ST_MUL_L && mul_ready) prod_keep <= mul_out;
  end

  dnc_scalar_adder scalar_adder (
    .CLK       (CLK),
    .RST       (RST),
    .START     (add_start),
    .OPERATION (add_op),
    .READY     (add_ready),
    .DATA_A_IN (add_a),
    .DATA_B_IN (add_b),
    .DATA_OUT  (add_out)
  );

  dnc_scalar_multiplier scalar_multiplier (
    .CLK       (CLK),
    .RST       (RST),
    .START     (mul_start),
    .READY     (mul_ready),
    .DATA_A_IN (mul_a),
    .DATA_B_IN (mul_b),
    .DATA_OUT  (mul_out)
  );

endmodule

`default_nettype wire

//--- src/dnc_link_memory.sv
`default_nettype none

module dnc_link_memory
  import dnc_pkg::*;
(
  input  wire logic        CLK,
  input  wire logic        RST,
  // Read side, combinational
  input  wire link_addr_t  rd_addr,
  output logic [DATA_SIZE-1:0] rd_data,
  // Write side, on the clock edge
  input  wire link_write_t wr
);

  //////////////////////////////////////////////////////////////////////
  // Link matrix storage, L[g][j]
  //////////////////////////////////////////////////////////////////////

  logic [DATA_SIZE-1:0] link_mem [MAX_N][MAX_N];

  assign rd_data = link_mem[rd_addr.g][rd_addr.j];

  // L(0) is all zeros
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int g = 0; g < MAX_N; g++) begin
        for (int j = 0; j < MAX_N; j++) begin
          link_mem[g][j] <= '0;
        end
      end
    end else if (wr.en) begin
      link_mem[wr.addr.g][wr.addr.j] <= wr.value;
    end
  end

endmodule

`default_nettype wire

//--- src/dnc_scalar_multiplier.sv
`default_nettype none

module dnc_scalar_multiplier
  import dnc_pkg::*;
(
  input  wire logic                 CLK,
  input  wire logic                 RST,
  // Control
  input  wire logic                 START,
  output logic                      READY,
  // Data
  input  wire logic [DATA_SIZE-1:0] DATA_A_IN,
  input  wire logic [DATA_SIZE-1:0] DATA_B_IN,
  output logic [DATA_SIZE-1:0]      DATA_OUT
);

  // Full Q16.16 product
  logic signed [2*DATA_SIZE-1:0] product;
  // Back to Q8.8 scale, still wide
  logic signed [2*DATA_SIZE-1:0] shifted;
  // Bits that must all match the sign for a clean fit
  logic [DATA_SIZE:0]            top_bits;
  logic [DATA_SIZE-1:0]          prod_sat;

  always_comb begin
    product  = signed'(DATA_A_IN) * signed'(DATA_B_IN);
    // Truncation toward minus infinity
    shifted  = product >>> FRAC_BITS;
    top_bits = shifted[2*DATA_SIZE-1:DATA_SIZE-1];
    if (top_bits == '0 || top_bits == '1) begin
      prod_sat = shifted[DATA_SIZE-1:0];
    end else if (shifted[2*DATA_SIZE-1]) begin
      prod_sat = DATA_MIN;
    end else begin
      prod_sat = DATA_MAX;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      READY <= 1'b0;
    end else begin
      READY <= START;
    end
  end

  // Product register, loaded on START only
  always_ff @(posedge CLK) begin
    if (START) begin
      DATA_OUT <= prod_sat;
    end
  end

endmodule

`default_nettype wire

//--- src/dnc_scalar_adder.sv
`default_nettype none

module dnc_scalar_adder
  import dnc_pkg::*;
(
  input  wire logic                 CLK,
  input  wire logic                 RST,
  // Control
  input  wire logic                 START,
  input  wire logic                 OPERATION,  // 1 = A - B
  output logic                      READY,
  // Data
  input  wire logic [DATA_SIZE-1:0] DATA_A_IN,
  input  wire logic [DATA_SIZE-1:0] DATA_B_IN,
  output logic [DATA_SIZE-1:0]      DATA_OUT
);

  // One guard bit above the sign
  logic signed [DATA_SIZE:0] a_ext;
  logic signed [DATA_SIZE:0] b_ext;
  logic signed [DATA_SIZE:0] sum_ext;
  logic [DATA_SIZE-1:0]      sum_sat;

  always_comb begin
    a_ext = {DATA_A_IN[DATA_SIZE-1], DATA_A_IN};
    b_ext = {DATA_B_IN[DATA_SIZE-1], DATA_B_IN};
    if (OPERATION) begin
      sum_ext = a_ext - b_ext;
    end else begin
      sum_ext = a_ext + b_ext;
    end
    // Guard and sign disagree on overflow
    if (sum_ext[DATA_SIZE] != sum_ext[DATA_SIZE-1]) begin
      sum_sat = sum_ext[DATA_SIZE] ? DATA_MIN : DATA_MAX;
    end else begin
      sum_sat = sum_ext[DATA_SIZE-1:0];
    end
  end

  // Result one cycle after START
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      READY <= 1'b0;
    end else begin
      READY <= START;
    end
  end

  // Held until the next START
  always_ff @(posedge CLK) begin
    if (START) begin
      DATA_OUT <= sum_sat;
    end
  end

endmodule

`default_nettype wire

//--- src/dnc_pkg.sv
`default_nettype none

package dnc_pkg;

  //////////////////////////////////////////////////////////////////////
  // Fixed point format
  //////////////////////////////////////////////////////////////////////

  // Signed Q8.8 word
  localparam int DATA_SIZE = 16;
  localparam int FRAC_BITS = 8;

  // 1.0 in Q8.8
  localparam logic [DATA_SIZE-1:0] ONE_DATA =
    {{(DATA_SIZE-FRAC_BITS-1){1'b0}}, 1'b1, {FRAC_BITS{1'b0}}};

  // Saturation limits
  localparam logic [DATA_SIZE-1:0] DATA_MAX = {1'b0, {(DATA_SIZE-1){1'b1}}};
  localparam logic [DATA_SIZE-1:0] DATA_MIN = {1'b1, {(DATA_SIZE-1){1'b0}}};

  //////////////////////////////////////////////////////////////////////
  // Link matrix geometry
  //////////////////////////////////////////////////////////////////////

  localparam int MAX_N      = 4;
  localparam int INDEX_SIZE = $clog2(MAX_N);

  // Row g, column j
  typedef struct packed {
    logic [INDEX_SIZE-1:0] g;
    logic [INDEX_SIZE-1:0] j;
  } link_addr_t;

  // One element write into the link memory
  typedef struct packed {
    logic                 en;
    link_addr_t           addr;
    logic [DATA_SIZE-1:0] value;
  } link_write_t;

endpackage

`default_nettype wire
